//--- Makefile
# Verilator build and run of the motion controller testbench

VERILATOR   ?= verilator
TOP         ?= motion_tb
FILELIST    ?= src.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= Everything OK
VFLAGS      ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/motion_consts.svh
`ifndef MOTION_CONSTS_SVH
`define MOTION_CONSTS_SVH

// Axis count, one SPI axis field covers up to four
`define NUM_AXES 4

// Queue depth per axis, also the credits each axis starts with
`define AXIS_CREDITS 2
`define CREDIT_W 2

// Move word field widths
`define STEPS_W 15
`define PERIOD_W 12

// Step pulse shape in CLK cycles
`define STEP_PULSE_CYCLES 2
`define MIN_PERIOD 4

`endif

//--- rtl/axis_cmd_if.sv
`include "motion_consts.svh"

// One move or config transfer toward an axis, credits flow back
interface axis_cmd_if;
  logic                 cmd_valid;     // Single-cycle strobe
  logic                 is_config;
  logic                 dir;
  logic [`STEPS_W-1:0]  steps;
  logic [`PERIOD_W-1:0] period;
  logic                 invert_dir;
  logic                 enable;
  logic                 credit_return; // One pulse per freed queue slot

  modport dispatch (
    output cmd_valid, is_config, dir, steps, period, invert_dir, enable,
    input  credit_return
  );

  modport axis (
    input  cmd_valid, is_config, dir, steps, period, invert_dir, enable,
    output credit_return
  );

  modport monitor (
    input cmd_valid, is_config, dir, steps, period, invert_dir, enable, credit_return
  );
endinterface

//--- rtl/motion_pkg.sv
`include "motion_consts.svh"

package motion_pkg;

  typedef enum logic [1:0] {
    op_nop    = 2'd0,
    op_move   = 2'd1,
    op_config = 2'd2
  } opcode_t;

  typedef struct packed {
    opcode_t              opcode;
    logic [1:0]           axis;
    logic                 dir;
    logic [`STEPS_W-1:0]  steps;
    logic [`PERIOD_W-1:0] period;
  } move_view_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [1:0]  axis;
    logic [25:0] reserved;
    logic        invert_dir;
    logic        enable;
  } config_view_t;

  // One SPI word, read as a move or as a config write by opcode
  typedef union packed {
    move_view_t   move;
    config_view_t cfg;
  } cmd_word_u;

  typedef struct packed {
    logic [7:0]           reserved_hi;
    logic [7:0]           reject_count;
    logic [`NUM_AXES-1:0] credit_avail;
    logic [`NUM_AXES-1:0] enabled;
    logic [`NUM_AXES-1:0] busy;
    logic                 move_done;
    logic [2:0]           reserved_lo;
  } status_word_t;

endpackage

//--- rtl/motion_top.sv
`include "motion_consts.svh"

module motion_top (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic                 sck,
  input  logic                 cs,
  input  logic                 copi,
  input  logic                 halt,
  output logic                 cipo,
  output logic [`NUM_AXES-1:0] step,
  output logic [`NUM_AXES-1:0] dir,
  output logic [`NUM_AXES-1:0] buffer_dtr,
  output logic                 move_done
);
  logic                     word_valid;
  motion_pkg::cmd_word_u    word;
  motion_pkg::status_word_t status_word;
  logic [`NUM_AXES-1:0]     credit_avail;
  logic [`NUM_AXES-1:0]     busy;
  logic [7:0]               reject_count;

  axis_cmd_if axis_bus [`NUM_AXES] ();

  spi_frame_rx u_spi (
    .CLK         (CLK),
    .resetn      (resetn),
    .sck         (sck),
    .cs          (cs),
    .copi        (copi),
    .cipo        (cipo),
    .status_word (status_word),
    .word_valid  (word_valid),
    .word        (word)
  );

  move_dispatcher u_dispatch (
    .CLK          (CLK),
    .resetn       (resetn),
    .word_valid   (word_valid),
    .word         (word),
    .axis         (axis_bus),
    .credit_avail (credit_avail),
    .reject_count (reject_count)
  );

  for (genvar g = 0; g < `NUM_AXES; g++) begin : g_axis
    step_axis u_axis (
      .CLK    (CLK),
      .resetn (resetn),
      .halt   (halt),
      .cmd    (axis_bus[g]),
      .step   (step[g]),
      .dir    (dir[g]),
      .busy   (busy[g])
    );
  end

  status_collector u_status (
    .CLK          (CLK),
    .resetn       (resetn),
    .busy         (busy),
    .credit_avail (credit_avail),
    .reject_count (reject_count),
    .mon          (axis_bus),
    .status_word  (status_word),
    .move_done    (move_done)
  );

  assign buffer_dtr = credit_avail;  // High while an axis can take another move
endmodule

//--- rtl/move_dispatcher.sv
`include "motion_consts.svh"

module move_dispatcher (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic                  word_valid,
  input  motion_pkg::cmd_word_u word,
  axis_cmd_if.dispatch          axis [`NUM_AXES],
  output logic [`NUM_AXES-1:0]  credit_avail,
  output logic [7:0]            reject_count
);
  logic                 is_move;
  logic                 is_cfg;
  logic                 period_ok;
  logic                 accept;
  logic                 reject;
  logic                 pl_is_config;
  logic                 pl_dir;
  logic                 pl_invert;
  logic                 pl_enable;
  logic [`STEPS_W-1:0]  pl_steps;
  logic [`PERIOD_W-1:0] pl_period;

  assign is_move   = word_valid && (word.move.opcode == motion_pkg::op_move);
  assign is_cfg    = word_valid && (word.cfg.opcode == motion_pkg::op_config);
  assign period_ok = (word.move.period >= `MIN_PERIOD);  // Room for pulse and low time
  assign accept    = is_move && period_ok && credit_avail[word.move.axis];
  assign reject    = is_move && !accept;

  // Payload shared by all axes, the valid strobe selects one
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      pl_is_config <= is_cfg;
      pl_dir       <= word.move.dir;
      pl_steps     <= word.move.steps;
      pl_period    <= word.move.period;
      pl_invert    <= word.cfg.invert_dir;
      pl_enable    <= word.cfg.enable;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn)
      reject_count <= 8'd0;
    else if (reject && (reject_count != 8'hff))
      reject_count <= reject_count + 8'd1;
  end

  for (genvar i = 0; i < `NUM_AXES; i++) begin : g_axis
    logic [`CREDIT_W-1:0] credits;
    logic                 sel;
    logic                 take;
    logic                 valid_q;

    assign sel  = (word.move.axis == i);
    assign take = accept && sel;

    always_ff @(posedge CLK) begin
      if (!resetn) begin
        valid_q <= 1'b0;
        credits <= `AXIS_CREDITS;
      end else begin
        valid_q <= sel && (accept || is_cfg);
        case ({take, axis[i].credit_return})
          2'b10:   credits <= credits - 1'b1;
          2'b01:   credits <= credits + 1'b1;
          default: credits <= credits;  // Both or neither cancel out
        endcase
      end
    end

    assign credit_avail[i]      = (credits != '0);
    assign axis[i].cmd_valid    = valid_q;
    assign axis[i].is_config    = pl_is_config;
    assign axis[i].dir          = pl_dir;
    assign axis[i].steps        = pl_steps;
    assign axis[i].period       = pl_period;
    assign axis[i].invert_dir   = pl_invert;
    assign axis[i].enable       = pl_enable;

    // Axis must never hand back more than was sent; an underflow wraps above the limit too
    assert property (@(posedge CLK) disable iff (!resetn) credits <= `AXIS_CREDITS);
  end
endmodule

//--- rtl/spi_frame_rx.sv
module spi_frame_rx (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic                     sck,
  input  logic                     cs,
  input  logic                     copi,
  output logic                     cipo,
  input  motion_pkg::status_word_t status_word,
  output logic                     word_valid,
  output motion_pkg::cmd_word_u    word
);
  logic [2:0]  sck_r;   // Two sync stages plus one for edge detect
  logic [2:0]  cs_r;
  logic [1:0]  copi_r;
  logic        sck_rise;
  logic        sck_fall;
  logic        cs_rise;
  logic        cs_fall;
  logic        active;
  logic [5:0]  bit_cnt;
  logic [31:0] rx_shift;
  logic [31:0] tx_shift;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;  // Bus idle, no frame
      copi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs};
      copi_r <= {copi_r[0], copi};
    end
  end

  assign sck_rise = sck_r[1] & ~sck_r[2];
  assign sck_fall = ~sck_r[1] & sck_r[2];
  assign cs_fall  = ~cs_r[1] & cs_r[2];
  assign cs_rise  = cs_r[1] & ~cs_r[2];
  assign active   = ~cs_r[1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt    <= 6'd0;
      tx_shift   <= 32'd0;
      word_valid <= 1'b0;
    end else begin
      if (cs_fall) begin
        bit_cnt  <= 6'd0;
        tx_shift <= status_word;  // Reply snapshot for this frame
      end else if (active && sck_rise) begin
        if (bit_cnt != 6'd63)
          bit_cnt <= bit_cnt + 6'd1;  // Saturates so long frames stay invalid
      end else if (active && sck_fall) begin
        tx_shift <= {tx_shift[30:0], 1'b0};
      end
      word_valid <= cs_rise && (bit_cnt == 6'd32);
    end
  end

  always_ff @(posedge CLK) begin
    if (active && sck_rise)
      rx_shift <= {rx_shift[30:0], copi_r[1]};  // MSB first
  end

  assign word = rx_shift;
  assign cipo = tx_shift[31];
endmodule

//--- rtl/status_collector.sv
`include "motion_consts.svh"

module status_collector (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic [`NUM_AXES-1:0]     busy,
  input  logic [`NUM_AXES-1:0]     credit_avail,
  input  logic [7:0]               reject_count,
  axis_cmd_if.monitor              mon [`NUM_AXES],
  output motion_pkg::status_word_t status_word,
  output logic                     move_done
);
  logic [`NUM_AXES-1:0] enabled;
  logic [`NUM_AXES-1:0] pending;

  for (genvar i = 0; i < `NUM_AXES; i++) begin : g_mon
    logic [`CREDIT_W-1:0] in_flight;  // Moves sent but not yet popped
    logic                 en_q;
    logic                 sent;

    assign sent = mon[i].cmd_valid && !mon[i].is_config;

    always_ff @(posedge CLK) begin
      if (!resetn) begin
        en_q      <= 1'b0;
        in_flight <= '0;
      end else begin
        if (mon[i].cmd_valid && mon[i].is_config)
          en_q <= mon[i].enable;
        case ({sent, mon[i].credit_return})
          2'b10:   in_flight <= in_flight + 1'b1;
          2'b01:   in_flight <= in_flight - 1'b1;
          default: in_flight <= in_flight;
        endcase
      end
    end

    assign enabled[i] = en_q;
    assign pending[i] = (in_flight != '0);
  end

  assign move_done = ~|busy && ~|pending;

  always_comb begin
    status_word              = '0;
    status_word.reject_count = reject_count;
    status_word.credit_avail = credit_avail;
    status_word.enabled      = enabled;
    status_word.busy         = busy;
    status_word.move_done    = move_done;
  end
endmodule

//--- rtl/step_axis.sv
`include "motion_consts.svh"

module step_axis (
  input  logic     CLK,
  input  logic     resetn,
  input  logic     halt,
  axis_cmd_if.axis cmd,
  output logic     step,
  output logic     dir,
  output logic     busy
);
  logic                 q_dir    [2];
  logic [`STEPS_W-1:0]  q_steps  [2];
  logic [`PERIOD_W-1:0] q_period [2];
  logic                 rd_ptr;
  logic [1:0]           q_cnt;
  logic                 wr_idx;
  logic                 enabled;
  logic                 invert;
  logic                 push;
  logic                 pop;
  logic                 rise;
  logic                 fall;
  logic [1:0]           ret_pend;   // Credits owed to the dispatcher
  logic [`STEPS_W-1:0]  steps_left;
  logic [`PERIOD_W-1:0] period_q;
  logic [`PERIOD_W-1:0] cnt;        // Cycles since last rising edge

  assign push   = cmd.cmd_valid && !cmd.is_config;
  assign pop    = enabled && !busy && (q_cnt != 2'd0) && !halt;
  assign wr_idx = rd_ptr ^ q_cnt[0];
  assign rise   = busy && !step && (steps_left != '0) && (cnt == period_q);
  assign fall   = step && (cnt == `STEP_PULSE_CYCLES);
  assign cmd.credit_return = (ret_pend != 2'd0);

  always_ff @(posedge CLK) begin
    if (push) begin
      q_dir[wr_idx]    <= cmd.dir;
      q_steps[wr_idx]  <= cmd.steps;
      q_period[wr_idx] <= cmd.period;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      rd_ptr   <= 1'b0;
      q_cnt    <= 2'd0;
      enabled  <= 1'b0;
      invert   <= 1'b0;
      ret_pend <= 2'd0;
    end else begin
      if (cmd.cmd_valid && cmd.is_config) begin
        enabled <= cmd.enable;
        invert  <= cmd.invert_dir;
      end
      if (halt) begin
        q_cnt    <= 2'd0;  // Everything queued, plus any arriving move, is handed back
        ret_pend <= ret_pend - 2'(cmd.credit_return) + q_cnt + 2'(push);
      end else begin
        rd_ptr   <= rd_ptr ^ pop;
        q_cnt    <= q_cnt + 2'(push) - 2'(pop);
        ret_pend <= ret_pend - 2'(cmd.credit_return) + 2'(pop);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy <= 1'b0;
      step <= 1'b0;
      dir  <= 1'b0;
    end else if (halt) begin
      busy <= 1'b0;
      step <= 1'b0;
    end else if (pop) begin
      busy <= 1'b1;
      dir  <= q_dir[rd_ptr] ^ invert;  // Held until the next pop
    end else if (fall) begin
      step <= 1'b0;
      busy <= (steps_left != '0);
    end else if (busy && !step && (steps_left == '0)) begin
      busy <= 1'b0;  // Zero-step move
    end else if (rise) begin
      step <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      steps_left <= q_steps[rd_ptr];
      period_q   <= q_period[rd_ptr];
      cnt        <= q_period[rd_ptr];  // First edge right after the pop
    end else if (rise) begin
      steps_left <= steps_left - 1'b1;
      cnt        <= 1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Dispatcher credits keep a full queue from being written
  assert property (@(posedge CLK) disable iff (!resetn) push |-> (q_cnt != 2'd2));
endmodule

//--- src.f
+incdir+include
rtl/motion_pkg.sv
rtl/axis_cmd_if.sv
rtl/spi_frame_rx.sv
rtl/move_dispatcher.sv
rtl/step_axis.sv
rtl/status_collector.sv
rtl/motion_top.sv
testbench/motion_tb.sv

//--- testbench/motion_tb.sv
`include "motion_consts.svh"

module motion_tb;
  localparam int MAX_STEPS    = 64;
  localparam int MAX_PERIOD   = 35;
  localparam int HALF_SCK     = 8;
  localparam int FRAME_CYCLES = 2 * HALF_SCK * 32 + 4 * HALF_SCK;
  // Six moves at the largest size plus every frame the sequence sends
  localparam int CYCLE_LIMIT  = 6 * MAX_STEPS * MAX_PERIOD + 24 * FRAME_CYCLES + 500;

  logic                 CLK = 1'b0;
  logic                 resetn;
  logic                 sck;
  logic                 cs;
  logic                 copi;
  logic                 halt;
  logic                 cipo;
  logic [`NUM_AXES-1:0] step;
  logic [`NUM_AXES-1:0] dir;
  logic [`NUM_AXES-1:0] buffer_dtr;
  logic                 move_done;

  int seed = 32'h0d8b7611;
  int cycles = 0;
  int fail_count = 0;
  int fails_before = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  motion_pkg::status_word_t reply;
  motion_pkg::status_word_t exp_status;
  logic [7:0]               exp_rejects;
  logic [`NUM_AXES-1:0]     en_mask;   // Axes the sequence has enabled
  int                       exp_steps;
  int                       exp_period;
  logic                     exp_dir1;
  logic                     reset_check;
  logic                     reply_check;
  logic                     reject_check;
  logic                     count_check;
  logic                     dtr_low_check;
  logic                     dtr_high_check;
  logic                     dir_check;
  logic                     after_halt;
  logic                     mon_clear;

  // Step monitor for axis 0
  logic step_prev;
  logic halt_d1;
  logic halt_d2;
  logic rise0;
  logic fall0;
  int   rise_count;
  int   rise_gap;
  int   high_len;

  motion_top uut (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs         (cs),
    .copi       (copi),
    .halt       (halt),
    .cipo       (cipo),
    .step       (step),
    .dir        (dir),
    .buffer_dtr (buffer_dtr),
    .move_done  (move_done)
  );

  always #2 CLK = ~CLK;

  assign rise0 = step[0] && !step_prev;
  assign fall0 = !step[0] && step_prev;

  always @(posedge CLK) begin
    step_prev <= step[0];
    halt_d1   <= halt;
    halt_d2   <= halt_d1;
    rise_gap  <= rise0 ? 1 : rise_gap + 1;
    high_len  <= step[0] ? high_len + 1 : 0;
    if (mon_clear)
      rise_count <= 0;
    else if (rise0)
      rise_count <= rise_count + 1;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string msg);
    fail_count++;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  assert property (@(posedge CLK) disable iff (!resetn)
    rise0 && rise_count != 0 |-> rise_gap == exp_period)
    else report_mismatch("step spacing on axis 0 differs from the move period");
  assert property (@(posedge CLK) disable iff (!resetn)
    fall0 && !halt_d1 |-> high_len == `STEP_PULSE_CYCLES)
    else report_mismatch("step pulse width on axis 0 is wrong");
  assert property (@(posedge CLK) disable iff (!resetn)
    count_check |-> rise_count == exp_steps)
    else report_mismatch("number of steps on axis 0 differs from the move");
  assert property (@(posedge CLK) disable iff (!resetn)
    dir_check && step[1] |-> dir[1] == !exp_dir1)
    else report_mismatch("dir on axis 1 ignores invert_dir");
  assert property (@(posedge CLK) disable iff (!resetn)
    dtr_low_check |-> !buffer_dtr[2])
    else report_mismatch("buffer_dtr on axis 2 high with no credit left");
  assert property (@(posedge CLK) disable iff (!resetn)
    dtr_high_check |-> buffer_dtr[2])
    else report_mismatch("buffer_dtr on axis 2 low after its queue drained");
  assert property (@(posedge CLK) disable iff (!resetn)
    reject_check |-> reply.reject_count == exp_rejects)
    else report_mismatch("reject count in the status reply is wrong");
  assert property (@(posedge CLK) disable iff (!resetn)
    halt |=> step == '0)
    else report_mismatch("step still high the cycle after halt");
  assert property (@(posedge CLK) disable iff (!resetn)
    after_halt |-> step == '0)
    else report_mismatch("step pulse after halt");
  assert property (@(posedge CLK) disable iff (!resetn)
    halt_d2 |-> buffer_dtr == '1 && move_done)
    else report_mismatch("credits or move_done not restored two cycles after halt");
  assert property (@(posedge CLK) disable iff (!resetn)
    reply_check |-> reply == exp_status)
    else report_mismatch("status reply differs from the expected word");
  assert property (@(posedge CLK) disable iff (!resetn)
    reset_check |-> step == '0 && dir == '0 && !cipo && buffer_dtr == '1 && move_done)
    else report_mismatch("outputs differ from their reset values");

  // Inputs change one time unit after the rising edge
  task automatic tick(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // SPI mode 0 host shifting MSB first
  task automatic spi_transfer(input logic [31:0] tx, output logic [31:0] rx);
    cs = 1'b0;
    tick(HALF_SCK);
    for (int i = 31; i >= 0; i--) begin
      copi = tx[i];
      tick(HALF_SCK);
      sck   = 1'b1;
      rx[i] = cipo;
      tick(HALF_SCK);
      sck = 1'b0;
    end
    tick(HALF_SCK);
    cs = 1'b1;
    tick(HALF_SCK);  // Frame decoded and dispatched by now
  endtask

  task automatic send_word(input logic [31:0] w);
    logic [31:0] unused;
    spi_transfer(w, unused);
  endtask

  function automatic logic [31:0] move_word(input logic [1:0] ax, input logic d,
                                            input int steps, input int period);
    return {2'd1, ax, d, steps[14:0], period[11:0]};
  endfunction

  function automatic logic [31:0] config_word(input logic [1:0] ax, input logic inv,
                                              input logic en);
    return {2'd2, ax, 26'd0, inv, en};
  endfunction

  // Nop frame whose reply is compared against the status layout
  task automatic check_reply(input logic [3:0] busy_mask, input logic [3:0] credit_mask,
                             input logic done);
    logic [31:0] rx;
    spi_transfer(32'd0, rx);
    reply      = rx;
    exp_status = {8'd0, exp_rejects, credit_mask, en_mask, busy_mask, done, 3'd0};
    reply_check = 1'b1;
    tick(1);
    reply_check = 1'b0;
  endtask

  task automatic wait_done();
    while (!move_done)
      tick(1);
  endtask

  task automatic end_test(input string name);
    if (fail_count == fails_before) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d check errors", name, fail_count - fails_before);
    end
    fails_before = fail_count;
  endtask

  initial begin
    logic [31:0] rx;
    int          st;
    int          pd;
    int          rnd;
    resetn         = 1'b0;
    sck            = 1'b0;
    cs             = 1'b1;
    copi           = 1'b0;
    halt           = 1'b0;
    exp_rejects    = 8'd0;
    en_mask        = '0;
    exp_steps      = 0;
    exp_period     = 0;
    exp_dir1       = 1'b0;
    reset_check    = 1'b0;
    reply_check    = 1'b0;
    reject_check   = 1'b0;
    count_check    = 1'b0;
    dtr_low_check  = 1'b0;
    dtr_high_check = 1'b0;
    dir_check      = 1'b0;
    after_halt     = 1'b0;
    mon_clear      = 1'b0;
    tick(5);
    resetn = 1'b1;
    tick(1);

    reset_check = 1'b1;
    tick(1);
    reset_check = 1'b0;
    check_reply(4'b0000, 4'b1111, 1'b1);
    end_test("reset");

    send_word(config_word(2'd0, 1'b0, 1'b1));
    en_mask[0] = 1'b1;
    st         = ($random(seed) & 63) + 1;
    pd         = ($random(seed) & 31) + `MIN_PERIOD;
    exp_steps  = st;
    exp_period = pd;
    mon_clear  = 1'b1;
    tick(1);
    mon_clear = 1'b0;
    send_word(move_word(2'd0, 1'b0, st, pd));
    wait_done();
    count_check = 1'b1;
    tick(1);
    count_check = 1'b0;
    end_test("steps");

    send_word(config_word(2'd1, 1'b1, 1'b1));
    en_mask[1] = 1'b1;
    rnd        = $random(seed);
    exp_dir1   = rnd[0];
    st         = ($random(seed) & 63) + 1;
    pd         = ($random(seed) & 31) + `MIN_PERIOD;
    dir_check  = 1'b1;
    send_word(move_word(2'd1, exp_dir1, st, pd));
    wait_done();
    dir_check = 1'b0;
    end_test("direction");

    // Axis 2 stays disabled so both moves wait in its queue
    st = ($random(seed) & 63) + 1;
    pd = ($random(seed) & 31) + `MIN_PERIOD;
    send_word(move_word(2'd2, 1'b0, st, pd));
    send_word(move_word(2'd2, 1'b1, st, pd));
    dtr_low_check = 1'b1;
    tick(1);
    dtr_low_check = 1'b0;
    send_word(move_word(2'd2, 1'b0, st, pd));  // No credit left
    send_word(move_word(2'd3, 1'b0, st, 3));   // Period below the minimum
    exp_rejects = exp_rejects + 8'd2;
    spi_transfer(32'd0, rx);
    reply        = rx;
    reject_check = 1'b1;
    tick(1);
    reject_check = 1'b0;
    send_word(config_word(2'd2, 1'b0, 1'b1));
    en_mask[2] = 1'b1;
    wait_done();
    dtr_high_check = 1'b1;
    tick(1);
    dtr_high_check = 1'b0;
    end_test("credits");

    exp_period = MAX_PERIOD;
    mon_clear  = 1'b1;
    tick(1);
    mon_clear = 1'b0;
    send_word(move_word(2'd0, 1'b1, MAX_STEPS, MAX_PERIOD));
    send_word(move_word(2'd0, 1'b0, MAX_STEPS, MAX_PERIOD));  // Sits in the queue
    while (rise_count < 3 || !step[0])
      tick(1);
    halt = 1'b1;  // Lands while a pulse is high
    tick(1);
    after_halt = 1'b1;
    tick(3);
    halt = 1'b0;
    tick(2 * MAX_PERIOD);
    after_halt = 1'b0;
    end_test("halt");

    mon_clear = 1'b1;
    tick(1);
    mon_clear = 1'b0;
    send_word(move_word(2'd0, 1'b0, MAX_STEPS, MAX_PERIOD));
    check_reply(4'b0001, 4'b1111, 1'b0);  // Latched mid-move
    wait_done();
    check_reply(4'b0000, 4'b1111, 1'b1);
    end_test("status");

    $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
             tests_passed, tests_failed, fail_count);
    if (tests_failed == 0 && fail_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end
endmodule
